// ==== hw/mipsAluPkg.sv ====
package mipsAluPkg;

    // Datapath and register file geometry
    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;
    localparam int NumRegs      = 32;
    localparam int OpWidth      = 6;                         // Opcode and funct width
    localparam int ImmWidth     = 16;                        // I-type immediate field

    // Primary opcodes
    localparam logic [OpWidth-1:0] OpRType = 6'b000000;
    localparam logic [OpWidth-1:0] OpAddi  = 6'b001000;
    localparam logic [OpWidth-1:0] OpSlti  = 6'b001010;
    localparam logic [OpWidth-1:0] OpAndi  = 6'b001100;
    localparam logic [OpWidth-1:0] OpOri   = 6'b001101;
    localparam logic [OpWidth-1:0] OpXori  = 6'b001110;

    // R-type funct field values
    localparam logic [OpWidth-1:0] FnAdd  = 6'b100000;
    localparam logic [OpWidth-1:0] FnAddu = 6'b100001;
    localparam logic [OpWidth-1:0] FnSub  = 6'b100010;
    localparam logic [OpWidth-1:0] FnSubu = 6'b100011;
    localparam logic [OpWidth-1:0] FnAnd  = 6'b100100;
    localparam logic [OpWidth-1:0] FnOr   = 6'b100101;
    localparam logic [OpWidth-1:0] FnXor  = 6'b100110;
    localparam logic [OpWidth-1:0] FnNor  = 6'b100111;
    localparam logic [OpWidth-1:0] FnSlt  = 6'b101010;

    // Operation class from the main decoder
    typedef enum logic [1:0] {
        ClassAdd   = 2'b00,                                  // Always add
        ClassSub   = 2'b01,                                  // Always subtract
        ClassFunct = 2'b10,                                  // Look at funct
        ClassImm   = 2'b11                                   // Look at opcode
    } aluOpClass_e;

    // ALU control codes
    typedef enum logic [3:0] {
        CtrlAnd     = 4'b0000,
        CtrlOr      = 4'b0001,
        CtrlAdd     = 4'b0010,
        CtrlSub     = 4'b0110,
        CtrlSlt     = 4'b0111,
        CtrlNor     = 4'b1100,
        CtrlXor     = 4'b1101,
        CtrlInvalid = 4'b1111                                // Unsupported instruction
    } aluCtrl_e;

    // Fields pulled out of one instruction
    typedef struct packed {
        logic [OpWidth-1:0]      opcode;
        logic [OpWidth-1:0]      funct;
        logic [RegAddrWidth-1:0] srcA;                       // rs
        logic [RegAddrWidth-1:0] srcB;                       // rt
        logic [RegAddrWidth-1:0] destReg;
        logic                    useImm;                     // Operand B from immediate
        logic [DataWidth-1:0]    immValue;                   // Already extended
        aluOpClass_e             opClass;
    } decodedInstr_t;

    // Write-back entry
    typedef struct packed {
        logic [RegAddrWidth-1:0] destReg;
        logic [DataWidth-1:0]    data;
    } execResult_t;

endpackage

// ==== hw/mainDecoder.sv ====
`timescale 1ns/1ps

module mainDecoder
(
    input  logic [mipsAluPkg::DataWidth-1:0] instr,
    output mipsAluPkg::decodedInstr_t        decoded
);

    logic [mipsAluPkg::OpWidth-1:0]      opcode;
    logic [mipsAluPkg::OpWidth-1:0]      funct;
    logic [mipsAluPkg::RegAddrWidth-1:0] rs;
    logic [mipsAluPkg::RegAddrWidth-1:0] rt;
    logic [mipsAluPkg::RegAddrWidth-1:0] rd;
    logic [mipsAluPkg::ImmWidth-1:0]     imm;
    logic [mipsAluPkg::DataWidth-1:0]    immSigned;
    logic [mipsAluPkg::DataWidth-1:0]    immZero;

    // Fixed MIPS field positions
    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];

    assign immSigned = {{(mipsAluPkg::DataWidth - mipsAluPkg::ImmWidth){imm[15]}}, imm};
    assign immZero   = {{(mipsAluPkg::DataWidth - mipsAluPkg::ImmWidth){1'b0}}, imm};

    always_comb
    begin
        decoded.opcode = opcode;
        decoded.funct  = funct;
        decoded.srcA   = rs;
        decoded.srcB   = rt;

        // I-type defaults, logical immediates zero-extend
        decoded.destReg  = rt;
        decoded.useImm   = 1'b1;
        decoded.immValue = immZero;
        decoded.opClass  = mipsAluPkg::ClassImm;

        case (opcode)
            mipsAluPkg::OpRType:
            begin
                decoded.destReg = rd;                        // R-type writes rd
                decoded.useImm  = 1'b0;
                decoded.opClass = mipsAluPkg::ClassFunct;
            end
            mipsAluPkg::OpAddi:
            begin
                decoded.immValue = immSigned;
                decoded.opClass  = mipsAluPkg::ClassAdd;     // No need to look further
            end
            mipsAluPkg::OpSlti:
            begin
                decoded.immValue = immSigned;                // Signed compare
            end
            default:
            begin
                // ANDI, ORI, XORI and anything unknown keep the defaults;
                // aluControl decides whether the opcode is legal
                decoded.immValue = immZero;
            end
        endcase
    end

endmodule

// ==== hw/aluControl.sv ====
`timescale 1ns/1ps

module aluControl
(
    input  mipsAluPkg::aluOpClass_e        opClass,
    input  logic [mipsAluPkg::OpWidth-1:0] funct,
    input  logic [mipsAluPkg::OpWidth-1:0] opcode,
    output mipsAluPkg::aluCtrl_e           aluCtrl
);

    always_comb
    begin
        aluCtrl = mipsAluPkg::CtrlInvalid;                   // Anything unlisted

        case (opClass)
            mipsAluPkg::ClassAdd:
            begin
                aluCtrl = mipsAluPkg::CtrlAdd;
            end
            mipsAluPkg::ClassSub:
            begin
                aluCtrl = mipsAluPkg::CtrlSub;
            end
            mipsAluPkg::ClassFunct:
            begin
                case (funct)
                    mipsAluPkg::FnAdd:  aluCtrl = mipsAluPkg::CtrlAdd;
                    mipsAluPkg::FnAddu: aluCtrl = mipsAluPkg::CtrlAdd;  // No overflow trap
                    mipsAluPkg::FnSub:  aluCtrl = mipsAluPkg::CtrlSub;
                    mipsAluPkg::FnSubu: aluCtrl = mipsAluPkg::CtrlSub;
                    mipsAluPkg::FnAnd:  aluCtrl = mipsAluPkg::CtrlAnd;
                    mipsAluPkg::FnOr:   aluCtrl = mipsAluPkg::CtrlOr;
                    mipsAluPkg::FnNor:  aluCtrl = mipsAluPkg::CtrlNor;
                    mipsAluPkg::FnXor:  aluCtrl = mipsAluPkg::CtrlXor;
                    mipsAluPkg::FnSlt:  aluCtrl = mipsAluPkg::CtrlSlt;
                    default:            aluCtrl = mipsAluPkg::CtrlInvalid;
                endcase
            end
            mipsAluPkg::ClassImm:
            begin
                case (opcode)
                    mipsAluPkg::OpSlti: aluCtrl = mipsAluPkg::CtrlSlt;
                    mipsAluPkg::OpAndi: aluCtrl = mipsAluPkg::CtrlAnd;
                    mipsAluPkg::OpOri:  aluCtrl = mipsAluPkg::CtrlOr;
                    mipsAluPkg::OpXori: aluCtrl = mipsAluPkg::CtrlXor;
                    default:            aluCtrl = mipsAluPkg::CtrlInvalid;
                endcase
            end
            default:
            begin
                aluCtrl = mipsAluPkg::CtrlInvalid;
            end
        endcase
    end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu
(
    input  mipsAluPkg::aluCtrl_e             aluCtrl,
    input  logic [mipsAluPkg::DataWidth-1:0] opA,
    input  logic [mipsAluPkg::DataWidth-1:0] opB,
    output logic [mipsAluPkg::DataWidth-1:0] aluOut,
    output logic                             ctrlInvalid
);

    logic [mipsAluPkg::DataWidth-1:0] sum;
    logic [mipsAluPkg::DataWidth-1:0] diff;
    logic                             lessThan;

    assign sum      = opA + opB;                             // Wraps, no carry out
    assign diff     = opA - opB;
    assign lessThan = $signed(opA) < $signed(opB);

    always_comb
    begin
        aluOut      = '0;
        ctrlInvalid = 1'b0;

        case (aluCtrl)
            mipsAluPkg::CtrlAnd:
            begin
                aluOut = opA & opB;
            end
            mipsAluPkg::CtrlOr:
            begin
                aluOut = opA | opB;
            end
            mipsAluPkg::CtrlAdd:
            begin
                aluOut = sum;
            end
            mipsAluPkg::CtrlSub:
            begin
                aluOut = diff;
            end
            mipsAluPkg::CtrlSlt:
            begin
                aluOut = {{(mipsAluPkg::DataWidth-1){1'b0}}, lessThan};
            end
            mipsAluPkg::CtrlNor:
            begin
                aluOut = ~(opA | opB);
            end
            mipsAluPkg::CtrlXor:
            begin
                aluOut = opA ^ opB;
            end
            default:
            begin
                ctrlInvalid = 1'b1;                          // CtrlInvalid or unknown code
            end
        endcase
    end

endmodule

// ==== hw/registerFile.sv ====
`timescale 1ns/1ps

module registerFile
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic [mipsAluPkg::RegAddrWidth-1:0] rdAddrA,
    input  logic [mipsAluPkg::RegAddrWidth-1:0] rdAddrB,
    output logic [mipsAluPkg::DataWidth-1:0]    rdDataA,
    output logic [mipsAluPkg::DataWidth-1:0]    rdDataB,
    input  logic                                wrEn,
    input  mipsAluPkg::execResult_t             wrEntry
);

    logic [mipsAluPkg::DataWidth-1:0] regs [mipsAluPkg::NumRegs];
    logic                             wrActive;

    assign wrActive = wrEn && (wrEntry.destReg != '0);       // r0 never written

    // Pending write is seen by a read in the same cycle
    function automatic logic [mipsAluPkg::DataWidth-1:0] readPort
    (
        input logic [mipsAluPkg::RegAddrWidth-1:0] addr
    );
        logic [mipsAluPkg::DataWidth-1:0] value;
        if (addr == '0)
            value = '0;
        else if (wrActive && (wrEntry.destReg == addr))
            value = wrEntry.data;                            // Write-through
        else
            value = regs[addr];
        return value;
    endfunction

    always_comb
    begin
        rdDataA = readPort(rdAddrA);
        rdDataB = readPort(rdAddrB);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < mipsAluPkg::NumRegs; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wrActive)
        begin
            regs[wrEntry.destReg] <= wrEntry.data;
        end
    end

endmodule

// ==== hw/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             instrValid,  // One-cycle strobe
    input  logic [mipsAluPkg::DataWidth-1:0] instr,
    output logic                             resultValid, // Pulse, also the write enable
    output mipsAluPkg::execResult_t          result,
    output logic                             illegalInstr
);

    mipsAluPkg::decodedInstr_t        decoded;
    mipsAluPkg::aluCtrl_e             aluCtrl;
    logic [mipsAluPkg::DataWidth-1:0] rdDataA;
    logic [mipsAluPkg::DataWidth-1:0] rdDataB;
    logic [mipsAluPkg::DataWidth-1:0] opB;
    logic [mipsAluPkg::DataWidth-1:0] aluOut;
    logic                             ctrlInvalid;

    mainDecoder mainDecoder0
    (
        .instr   (instr),
        .decoded (decoded)
    );

    registerFile registerFile0
    (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (decoded.srcA),
        .rdAddrB (decoded.srcB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (resultValid),                              // Write-back of last result
        .wrEntry (result)
    );

    aluControl aluControl0
    (
        .opClass (decoded.opClass),
        .funct   (decoded.funct),
        .opcode  (decoded.opcode),
        .aluCtrl (aluCtrl)
    );

    assign opB = decoded.useImm ? decoded.immValue : rdDataB;

    alu alu0
    (
        .aluCtrl     (aluCtrl),
        .opA         (rdDataA),
        .opB         (opB),
        .aluOut      (aluOut),
        .ctrlInvalid (ctrlInvalid)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            resultValid  <= 1'b0;
            illegalInstr <= 1'b0;
            result       <= '0;
        end
        else
        begin
            resultValid  <= instrValid && !ctrlInvalid;
            illegalInstr <= instrValid && ctrlInvalid;       // Nothing written
            if (instrValid && !ctrlInvalid)
            begin
                result.destReg <= decoded.destReg;
                result.data    <= aluOut;
            end
        end
    end

endmodule

// ==== tb/executeUnit_asserts.sv ====
`timescale 1ns/1ps

module executeUnitAsserts
(
    input logic clk,
    input logic rst,
    input logic instrValid,
    input logic resultValid,
    input logic illegalInstr
);

    onePulseKind: assert property (@(posedge clk) disable iff (rst)
        !(resultValid && illegalInstr))
        else $error("resultValid and illegalInstr are high in the same cycle");

    // Every accepted instruction gives exactly one outcome a cycle later
    pulseAfterIssue: assert property (@(posedge clk) disable iff (rst)
        instrValid |=> (resultValid || illegalInstr))
        else $error("No output pulse one cycle after instrValid");

    noPulseWithoutIssue: assert property (@(posedge clk) disable iff (rst)
        (resultValid || illegalInstr) |-> $past(instrValid))
        else $error("Output pulse without instrValid in the previous cycle");

    quietInReset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> !(resultValid || illegalInstr))
        else $error("Output pulse while rst is high");

endmodule

bind executeUnit executeUnitAsserts asserts0
(
    .clk          (clk),
    .rst          (rst),
    .instrValid   (instrValid),
    .resultValid  (resultValid),
    .illegalInstr (illegalInstr)
);

// ==== tb/executeUnitTb.sv ====
`timescale 1ns/1ps

module executeUnitTb;

    typedef logic [mipsAluPkg::NumRegs-1:0][mipsAluPkg::DataWidth-1:0] regArray_t;

    localparam int          PulseTimeout = 4;                // Cycles from issue to pulse
    localparam int          DrainTimeout = 50;
    localparam logic [31:0] LfsrTaps     = 32'h80200003;     // x^32+x^22+x^2+x+1
    localparam logic [5:0]  RFuncts [9]  = '{mipsAluPkg::FnAdd, mipsAluPkg::FnAddu,
        mipsAluPkg::FnSub, mipsAluPkg::FnSubu, mipsAluPkg::FnAnd, mipsAluPkg::FnOr,
        mipsAluPkg::FnNor, mipsAluPkg::FnXor, mipsAluPkg::FnSlt};
    localparam logic [5:0]  IOps [5]     = '{mipsAluPkg::OpAddi, mipsAluPkg::OpSlti,
        mipsAluPkg::OpAndi, mipsAluPkg::OpOri, mipsAluPkg::OpXori};

    logic                    clk;
    logic                    rst;
    logic                    instrValid;
    logic [31:0]             instr;
    logic                    resultValid;
    mipsAluPkg::execResult_t result;
    logic                    illegalInstr;
    regArray_t               modelRegs;                      // Architectural state, r0 stays 0
    logic [31:0]             lfsrState;
    int                      errorCount;
    int                      timeoutCount;
    bit                      timedOut;
    mipsAluPkg::execResult_t expResultQ[$];
    bit                      expIllegalQ[$];
    string                   nameQ[$];

    executeUnit dut0
    (
        .clk          (clk),
        .rst          (rst),
        .instrValid   (instrValid),
        .instr        (instr),
        .resultValid  (resultValid),
        .result       (result),
        .illegalInstr (illegalInstr)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LfsrTaps) : (state >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            value     = {value[30:0], lfsrState[0]};           // Bit shifted out this step
            lfsrState = lfsrStep(lfsrState);
        end
        return value;
    endfunction

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
        return {mipsAluPkg::OpRType, rs, rt, rd, 5'b00000, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mipsAluPkg::execResult_t refExecute(input logic [31:0] ins,
                                                           input regArray_t regs,
                                                           output bit illegal);
        mipsAluPkg::execResult_t res;
        logic [31:0]             a;
        logic [31:0]             b;
        logic [31:0]             sext;
        logic [31:0]             zext;
        a           = regs[ins[25:21]];
        b           = regs[ins[20:16]];
        sext        = {{16{ins[15]}}, ins[15:0]};
        zext        = {16'h0000, ins[15:0]};
        illegal     = 1'b0;
        res.destReg = (ins[31:26] == mipsAluPkg::OpRType) ? ins[15:11] : ins[20:16];
        res.data    = '0;
        if (ins[31:26] == mipsAluPkg::OpRType)
        begin
            case (ins[5:0])
                mipsAluPkg::FnAdd, mipsAluPkg::FnAddu: res.data = a + b;
                mipsAluPkg::FnSub, mipsAluPkg::FnSubu: res.data = a - b;
                mipsAluPkg::FnAnd: res.data = a & b;
                mipsAluPkg::FnOr:  res.data = a | b;
                mipsAluPkg::FnNor: res.data = ~(a | b);
                mipsAluPkg::FnXor: res.data = a ^ b;
                mipsAluPkg::FnSlt: res.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default:           illegal = 1'b1;
            endcase
        end
        else
        begin
            case (ins[31:26])
                mipsAluPkg::OpAddi: res.data = a + sext;
                mipsAluPkg::OpSlti: res.data = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
                mipsAluPkg::OpAndi: res.data = a & zext;
                mipsAluPkg::OpOri:  res.data = a | zext;
                mipsAluPkg::OpXori: res.data = a ^ zext;
                default:            illegal = 1'b1;
            endcase
        end
        return res;
    endfunction

    task automatic issue(input string name, input logic [31:0] ins);
        mipsAluPkg::execResult_t expected;
        bit                      illegal;
        expected = refExecute(ins, modelRegs, illegal);
        if (!illegal && (expected.destReg != 5'd0))
            modelRegs[expected.destReg] = expected.data;     // Program order, forwarding in DUT
        @(posedge clk);
        instrValid <= 1'b1;
        instr      <= ins;
        expResultQ.push_back(expected);
        expIllegalQ.push_back(illegal);
        nameQ.push_back(name);
    endtask

    task automatic idle(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            @(posedge clk);
            instrValid <= 1'b0;
        end
    endtask

    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while ((nameQ.size() != 0) && (cycles < DrainTimeout))
        begin
            @(posedge clk);
            cycles++;
        end
        if (nameQ.size() != 0)
        begin
            timeoutCount++;
            $display("Timed out with %0d results still outstanding", nameQ.size());
        end
    endtask

    task automatic checkResult(input string name, input mipsAluPkg::execResult_t expected,
                               input mipsAluPkg::execResult_t actual);
        if (actual !== expected)
        begin
            errorCount++;
            $display("[ERROR] %s: expected r%0d=%h, actual r%0d=%h", name,
                     expected.destReg, expected.data, actual.destReg, actual.data);
        end
    endtask

    task automatic checkIllegal(input string name, input bit expected, input bit actual);
        if (actual !== expected)
        begin
            errorCount++;
            $display("[ERROR] %s: illegal expected %0b, actual %0b", name, expected, actual);
        end
    endtask

    task automatic finishRun();
        $display("Errors: %0d, timeouts: %0d", errorCount, timeoutCount);
        if ((errorCount == 0) && (timeoutCount == 0))
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    endtask

    // Compare each pulse, sampled mid-cycle, with the oldest expectation
    initial
    begin
        mipsAluPkg::execResult_t expRes;
        bit                      expIll;
        string                   name;
        int                      waited;
        waited = 0;
        while (!timedOut)
        begin
            @(negedge clk);
            if (!rst && (resultValid || illegalInstr))
            begin
                waited = 0;
                if (nameQ.size() == 0)
                begin
                    errorCount++;
                    $display("Output pulse with no instruction outstanding at %0t", $time);
                end
                else
                begin
                    expRes = expResultQ.pop_front();
                    expIll = expIllegalQ.pop_front();
                    name   = nameQ.pop_front();
                    checkIllegal(name, expIll, illegalInstr && !resultValid);
                    if (!expIll)
                        checkResult(name, expRes, result);
                end
            end
            else if (nameQ.size() != 0)
            begin
                waited++;
                if (waited > PulseTimeout)
                begin
                    timeoutCount++;
                    timedOut = 1'b1;
                    $display("No output pulse arrived for %s", nameQ[0]);
                end
            end
        end
        finishRun();
    end

    initial
    begin
        logic [15:0] imm;
        rst          = 1'b1;
        instrValid   = 1'b0;
        instr        = '0;
        modelRegs    = '0;
        lfsrState    = 32'hc0bb;
        errorCount   = 0;
        timeoutCount = 0;
        timedOut     = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        idle(4);                                             // Any pulse here is flagged
        for (int i = 0; i < 32; i++)
            issue($sformatf("reset read r%0d", i), rType(5'(i), 5'd0, 5'd0, mipsAluPkg::FnAddu));
        for (int i = 1; i <= 8; i++)
        begin
            imm     = 16'(randBits(16));
            imm[15] = i[0];                                  // Odd registers negative
            issue("load addi", iType(mipsAluPkg::OpAddi, 5'd0, 5'(i), imm));
            issue("load ori", iType(mipsAluPkg::OpOri, 5'(i), 5'(i), 16'(randBits(16))));
        end
        issue("slt neg pos", rType(5'd1, 5'd2, 5'd9, mipsAluPkg::FnSlt));
        issue("slt pos neg", rType(5'd2, 5'd1, 5'd9, mipsAluPkg::FnSlt));
        issue("add wrap", rType(5'd1, 5'd3, 5'd10, mipsAluPkg::FnAdd));
        issue("sub wrap", rType(5'd2, 5'd1, 5'd11, mipsAluPkg::FnSubu));
        for (int f = 0; f < 9; f++)
            for (int rep = 0; rep < 3; rep++)
                issue($sformatf("rtype funct %h", RFuncts[f]), rType(5'(1 + randBits(3)),
                      5'(1 + randBits(3)), 5'(9 + randBits(3)), RFuncts[f]));
        for (int op = 0; op < 5; op++)
            for (int rep = 0; rep < 4; rep++)
            begin
                imm     = 16'(randBits(16));
                imm[15] = (rep % 2 == 0);                    // Sign versus zero extension
                issue($sformatf("itype op %h", IOps[op]),
                      iType(IOps[op], 5'(1 + randBits(3)), 5'(17 + randBits(3)), imm));
            end
        idle(2);
        issue("chain addu", rType(5'd1, 5'd2, 5'd21, mipsAluPkg::FnAddu));
        issue("chain addi", iType(mipsAluPkg::OpAddi, 5'd21, 5'd21, 16'(randBits(16))));
        issue("chain xor", rType(5'd21, 5'd3, 5'd22, mipsAluPkg::FnXor));
        issue("chain sub", rType(5'd22, 5'd21, 5'd23, mipsAluPkg::FnSub));
        issue("chain slt", rType(5'd23, 5'd22, 5'd24, mipsAluPkg::FnSlt));
        idle(2);
        issue("illegal funct", rType(5'd1, 5'd2, 5'd10, 6'h3f));
        issue("illegal opcode", iType(6'h23, 5'd1, 5'd11, 16'h1234));
        issue("r10 after illegal", rType(5'd10, 5'd0, 5'd0, mipsAluPkg::FnAddu));
        issue("r11 after illegal", rType(5'd11, 5'd0, 5'd0, mipsAluPkg::FnAddu));
        issue("addi to r0", iType(mipsAluPkg::OpAddi, 5'd1, 5'd0, 16'h7abc));
        issue("or to r0", rType(5'd1, 5'd2, 5'd0, mipsAluPkg::FnOr));
        issue("read r0", rType(5'd0, 5'd0, 5'd25, mipsAluPkg::FnAddu));
        idle(1);
        waitDrain();
        idle(4);
        finishRun();
    end

endmodule

// ==== executeUnit.f ====
hw/mipsAluPkg.sv
hw/mainDecoder.sv
hw/aluControl.sv
hw/alu.sv
hw/registerFile.sv
hw/executeUnit.sv
tb/executeUnit_asserts.sv
tb/executeUnitTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= executeUnitTb
FILELIST  ?= executeUnit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert
PASS_MSG  ?= TEST PASS

.PHONY: sim clean

# Build, run, and succeed only if the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
